//--- all.f
+incdir+hw
hw/corelet_pkg.sv
hw/mac_tile.sv
hw/mac_array.sv
hw/l0_buffer.sv
hw/psum_accum.sv
hw/corelet_ctrl.sv
hw/corelet.sv
dv/tb_corelet.sv

//--- Bender.yml
package:
  name: corelet

sources:
  - include_dirs:
      - hw
    files:
      - hw/corelet_pkg.sv
      - hw/mac_tile.sv
      - hw/mac_array.sv
      - hw/l0_buffer.sv
      - hw/psum_accum.sv
      - hw/corelet_ctrl.sv
      - hw/corelet.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_corelet.sv

//--- dv/tb_corelet.sv
`include "corelet_macros.svh"

module tb_corelet;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RUNS = 3;
    localparam int PASS_LEN = `LEN_WEIGHT_L0 + `LEN_WEIGHT_ARRAY + `LEN_ACT_L0
                            + `LEN_ACT_ARRAY + `LEN_WEIGHT_CLEAR;
    localparam int RUN_LEN  = `NUM_KIJ * PASS_LEN + `LEN_RET_OUT + 1;
    localparam int TIMEOUT  = NUM_RUNS * (RUN_LEN + RUN_LEN / 4); // quarter margin per run

    logic                           clk;
    logic                           reset;
    logic                           start;
    logic [`ARRAY_DIM*`ACT_BW-1:0]  i_q;
    corelet_pkg::fetch_t            i_fetch;
    corelet_pkg::out_wr_t           o_wr;
    logic                           done;

    logic [31:0]                    in_mem [128];
    logic [`ARRAY_DIM*`PSUM_BW-1:0] exp_word [`NUM_OUT];
    logic [31:0]                    lcg_state;
    int                             fetch_q [$];
    bit                             written [`NUM_OUT];
    int                             writes;
    int                             cycles;
    bit                             busy;
    bit                             pend_en;
    logic [`IADDR_BW-1:0]           pend_addr;
    bit                             prev_final_write;

    corelet UUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .i_q     (i_q),
        .i_fetch (i_fetch),
        .o_wr    (o_wr),
        .done    (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // top-left pixel of kernel position k in the 6x6 image
    function automatic int act_offset(input int k);
        case (k)
            1:       return 1;
            2:       return 2;
            3:       return 6;
            4:       return 7;
            5:       return 8;
            6:       return 12;
            7:       return 13;
            8:       return 14;
            default: return 0;
        endcase
    endfunction

    function automatic int act_addr(input int k, input int o);
        return `ACT_BASE + act_offset(k) + o + 2 * (o / 4);
    endfunction

    task automatic fill_memory();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int a = 0; a < 128; a++)
        begin
            hi = lcg_next();
            lo = lcg_next();
            in_mem[a] = {hi[31:16], lo[31:16]}; // upper lcg bits only
        end
    endtask

    // expected outputs and fetch order of one run
    task automatic predict_run();
        int                 sum;
        logic [3:0]         act;
        logic signed [3:0]  wgt;
        fetch_q.delete();
        for (int k = 0; k < `NUM_KIJ; k++)
        begin
            for (int c = 0; c < `ARRAY_DIM; c++)
                fetch_q.push_back(k * `ARRAY_DIM + c);
            for (int o = 0; o < `NUM_OUT; o++)
                fetch_q.push_back(act_addr(k, o));
        end
        for (int o = 0; o < `NUM_OUT; o++)
        begin
            for (int c = 0; c < `ARRAY_DIM; c++)
            begin
                sum = 0;
                for (int k = 0; k < `NUM_KIJ; k++)
                begin
                    for (int r = 0; r < `ARRAY_DIM; r++)
                    begin
                        act = in_mem[act_addr(k, o)][r*4 +: 4];
                        wgt = in_mem[k * `ARRAY_DIM + c][r*4 +: 4];
                        sum = sum + int'(act) * int'(wgt);
                    end
                end
                exp_word[o][c*`PSUM_BW +: `PSUM_BW] = sum[15:0]; // 16-bit wrap
            end
        end
    endtask

    task automatic run_once(input int run);
        fill_memory();
        predict_run();
        writes = 0;
        for (int i = 0; i < `NUM_OUT; i++)
            written[i] = 1'b0;
        @(negedge clk);
        start = 1'b1;
        busy  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        do
            @(negedge clk);
        while (!done);
        repeat (3) @(negedge clk); // done must drop again while idle
        assert (fetch_q.size() == 0)
        else stop_with_error($sformatf("run %0d left %0d expected fetches unissued",
                                       run, fetch_q.size()));
    endtask

    // sram model and output monitor on the falling edge
    always @(negedge clk)
    begin
        i_q       <= pend_en ? in_mem[pend_addr] : '0;
        pend_en   = i_fetch.en;
        pend_addr = i_fetch.addr;
        if (!reset)
        begin
            if (!busy)
                assert (!i_fetch.en && !o_wr.en && !done)
                else stop_with_error("fetch, write or done active while the core is idle");
            if (i_fetch.en)
            begin
                assert (fetch_q.size() > 0)
                else stop_with_error("fetch issued beyond the expected sequence");
                assert (int'(i_fetch.addr) == fetch_q[0])
                else stop_with_error($sformatf("Mismatch fetch %0d expected %0d actual %0d",
                                               fetch_q.size(), fetch_q[0], i_fetch.addr));
                void'(fetch_q.pop_front());
            end
            if (o_wr.en)
            begin
                assert (!written[o_wr.addr])
                else stop_with_error($sformatf("output address %0d written twice", o_wr.addr));
                written[o_wr.addr] = 1'b1;
                writes = writes + 1;
                assert (o_wr.data == exp_word[o_wr.addr])
                else stop_with_error($sformatf("Mismatch out_addr %0d expected %h actual %h",
                                               o_wr.addr, exp_word[o_wr.addr], o_wr.data));
            end
            if (done)
            begin
                assert (writes == `NUM_OUT && prev_final_write)
                else stop_with_error("done pulse not directly after the last output write");
                busy = 1'b0;
            end
            prev_final_write = o_wr.en && o_wr.addr == `OADDR_BW'(`NUM_OUT - 1);
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        assert (cycles <= TIMEOUT)
        else stop_with_error($sformatf("timeout after %0d cycles", cycles));
    end

    initial
    begin
        reset            = 1'b1;
        start            = 1'b0;
        i_q              = '0;
        busy             = 1'b0;
        pend_en          = 1'b0;
        pend_addr        = '0;
        prev_final_write = 1'b0;
        writes           = 0;
        cycles           = 0;
        lcg_state        = 32'd44135;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk); // idle outputs checked by the monitor
        for (int run = 0; run < NUM_RUNS; run++)
            run_once(run);
        $display("Test OK");
        $finish;
    end

endmodule

//--- hw/corelet.sv
`include "corelet_macros.svh"

module corelet (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [`ARRAY_DIM*`ACT_BW-1:0]   i_q,
    output corelet_pkg::fetch_t             i_fetch,
    output corelet_pkg::out_wr_t            o_wr,
    output logic                            done
);

    logic                   l0_wr;
    logic                   l0_rd;
    corelet_pkg::array_op_t array_op;
    logic                   array_clear;
    logic                   accum_clear;
    logic                   out_en;
    logic [`OADDR_BW-1:0]   out_idx;

    corelet_pkg::lane_t     west [`ARRAY_DIM];
    corelet_pkg::psum_row_t array_out;
    logic [`ARRAY_DIM-1:0]  col_valid;

    corelet_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .i_fetch     (i_fetch),
        .l0_wr       (l0_wr),
        .l0_rd       (l0_rd),
        .array_op    (array_op),
        .array_clear (array_clear),
        .accum_clear (accum_clear),
        .out_en      (out_en),
        .out_idx     (out_idx),
        .done        (done)
    );

    // sram data comes back straight into the row queues
    l0_buffer u_l0 (
        .clk     (clk),
        .reset   (reset),
        .wr      (l0_wr),
        .rd      (l0_rd),
        .op      (array_op),
        .in_word (i_q),
        .west    (west)
    );

    mac_array u_mac_array (
        .clk       (clk),
        .reset     (reset),
        .clear     (array_clear),
        .west      (west),
        .out_s     (array_out),
        .col_valid (col_valid)
    );

    psum_accum u_accum (
        .clk       (clk),
        .reset     (reset),
        .clear     (accum_clear),
        .psum      (array_out),
        .col_valid (col_valid),
        .out_en    (out_en),
        .out_idx   (out_idx),
        .o_wr      (o_wr)
    );

endmodule

//--- hw/corelet_ctrl.sv
`include "corelet_macros.svh"

module corelet_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output corelet_pkg::fetch_t     i_fetch,
    output logic                    l0_wr,
    output logic                    l0_rd,
    output corelet_pkg::array_op_t  array_op,
    output logic                    array_clear,
    output logic                    accum_clear,
    output logic                    out_en,
    output logic [`OADDR_BW-1:0]    out_idx,
    output logic                    done
);

    corelet_pkg::ctrl_state_t state, state_n;
    logic [5:0]             cnt, cnt_n;
    logic [3:0]             kij, kij_n; // kernel position of the current pass
    logic [5:0]             last_cnt;
    logic                   last;
    logic [4:0]             act_off;
    logic                   fetch_en;
    logic                   load_rd;
    logic                   exec_rd;
    logic [`IADDR_BW-1:0]   wgt_addr;
    logic [`IADDR_BW-1:0]   act_addr;

    always_comb
    begin
        case (state)
            corelet_pkg::WEIGHT_L0:    last_cnt = 6'(`LEN_WEIGHT_L0 - 1);
            corelet_pkg::WEIGHT_ARRAY: last_cnt = 6'(`LEN_WEIGHT_ARRAY - 1);
            corelet_pkg::ACT_L0:       last_cnt = 6'(`LEN_ACT_L0 - 1);
            corelet_pkg::ACT_ARRAY:    last_cnt = 6'(`LEN_ACT_ARRAY - 1);
            corelet_pkg::WEIGHT_CLEAR: last_cnt = 6'(`LEN_WEIGHT_CLEAR - 1);
            corelet_pkg::RET_OUT:      last_cnt = 6'(`LEN_RET_OUT - 1);
            default:                   last_cnt = '0;
        endcase
    end

    assign last = (cnt == last_cnt);

    always_comb
    begin
        state_n = state;
        kij_n   = kij;
        cnt_n   = last ? 6'd0 : cnt + 6'd1;
        case (state)
            corelet_pkg::IDLE:
            begin
                cnt_n = '0;
                if (start)
                begin
                    state_n = corelet_pkg::WEIGHT_L0;
                    kij_n   = '0;
                end
            end
            corelet_pkg::WEIGHT_L0:    if (last) state_n = corelet_pkg::WEIGHT_ARRAY;
            corelet_pkg::WEIGHT_ARRAY: if (last) state_n = corelet_pkg::ACT_L0;
            corelet_pkg::ACT_L0:       if (last) state_n = corelet_pkg::ACT_ARRAY;
            corelet_pkg::ACT_ARRAY:    if (last) state_n = corelet_pkg::WEIGHT_CLEAR;
            corelet_pkg::WEIGHT_CLEAR:
            begin
                if (last && kij == 4'(`NUM_KIJ - 1))
                    state_n = corelet_pkg::RET_OUT;
                else if (last)
                begin
                    state_n = corelet_pkg::WEIGHT_L0;
                    kij_n   = kij + 4'd1;
                end
            end
            corelet_pkg::RET_OUT:      if (last) state_n = corelet_pkg::IDLE;
            default:                   state_n = corelet_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= corelet_pkg::IDLE;
            cnt   <= '0;
            kij   <= '0;
            l0_wr <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            state <= state_n;
            cnt   <= cnt_n;
            kij   <= kij_n;
            l0_wr <= fetch_en; // sram answers one cycle later
            done  <= out_en && out_idx == `OADDR_BW'(`NUM_OUT - 1);
        end
    end

    // top-left input pixel of each kernel position in the 6x6 image
    always_comb
    begin
        case (kij)
            4'd1:    act_off = 5'd1;
            4'd2:    act_off = 5'd2;
            4'd3:    act_off = 5'd6;
            4'd4:    act_off = 5'd7;
            4'd5:    act_off = 5'd8;
            4'd6:    act_off = 5'd12;
            4'd7:    act_off = 5'd13;
            4'd8:    act_off = 5'd14;
            default: act_off = 5'd0;
        endcase
    end

    assign wgt_addr = `IADDR_BW'(kij * `ARRAY_DIM + cnt);
    // skip two edge pixels after every output row of four
    assign act_addr = `IADDR_BW'(`ACT_BASE + act_off + cnt + {cnt[3:2], 1'b0});

    assign fetch_en = (state == corelet_pkg::WEIGHT_L0 && cnt < `ARRAY_DIM)
                   || (state == corelet_pkg::ACT_L0 && cnt < `NUM_OUT);
    assign i_fetch  = '{en: fetch_en,
                        addr: (state == corelet_pkg::ACT_L0) ? act_addr : wgt_addr};

    assign load_rd  = (state == corelet_pkg::WEIGHT_ARRAY) && cnt < `ARRAY_DIM;
    assign exec_rd  = (state == corelet_pkg::ACT_ARRAY) && cnt < `NUM_OUT;
    assign l0_rd    = load_rd || exec_rd;
    assign array_op = load_rd ? corelet_pkg::OP_LOAD
                    : (exec_rd ? corelet_pkg::OP_EXEC : corelet_pkg::OP_NONE);

    // array is idle by then, clear mid-phase
    assign array_clear = (state == corelet_pkg::WEIGHT_CLEAR) && cnt >= 6'd9 && cnt <= 6'd12;
    assign accum_clear = (state == corelet_pkg::IDLE) && start;

    assign out_en  = (state == corelet_pkg::RET_OUT) && cnt < `NUM_OUT;
    assign out_idx = cnt[`OADDR_BW-1:0];

endmodule

//--- hw/psum_accum.sv
`include "corelet_macros.svh"

module psum_accum (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  corelet_pkg::psum_row_t  psum,
    input  logic [`ARRAY_DIM-1:0]   col_valid,
    input  logic                    out_en,
    input  logic [`OADDR_BW-1:0]    out_idx,
    output corelet_pkg::out_wr_t    o_wr
);

    corelet_pkg::psum_row_t rd_row;

    for (genvar c = 0; c < `ARRAY_DIM; c++)
    begin : g_col
        logic [`PSUM_BW-1:0]  entry [`NUM_OUT];
        logic [`OADDR_BW-1:0] ptr; // wraps back to 0 after each pass

        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
                ptr <= '0;
            else if (clear)
                ptr <= '0;
            else if (col_valid[c])
                ptr <= ptr + 1'b1;
        end

        always_ff @(posedge clk)
        begin
            if (clear)
            begin
                for (int i = 0; i < `NUM_OUT; i++)
                    entry[i] <= '0;
            end
            else if (col_valid[c])
                entry[ptr] <= entry[ptr] + psum[c];
        end

        assign rd_row[c] = entry[out_idx];
    end

    // one output pixel, all eight channels
    assign o_wr = '{en: out_en, addr: out_idx, data: rd_row};

endmodule

//--- hw/l0_buffer.sv
`include "corelet_macros.svh"

module l0_buffer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr,
    input  logic                            rd,
    input  corelet_pkg::array_op_t          op,
    input  logic [`ARRAY_DIM*`ACT_BW-1:0]   in_word,
    output corelet_pkg::lane_t              west [`ARRAY_DIM]
);

    localparam int DEPTH = `NUM_OUT;
    localparam int PTR_W = $clog2(DEPTH);

    // all rows push and pop together
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    for (genvar r = 0; r < `ARRAY_DIM; r++)
    begin : g_row
        logic [`ACT_BW-1:0] queue [DEPTH];
        corelet_pkg::lane_t dly [r+1]; // row r waits r extra cycles

        always_ff @(posedge clk)
        begin
            if (wr)
                queue[wr_ptr] <= in_word[r*`ACT_BW +: `ACT_BW];
        end

        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
            begin
                for (int j = 0; j <= r; j++)
                    dly[j] <= '0;
            end
            else
            begin
                dly[0].op  <= rd ? op : corelet_pkg::OP_NONE;
                dly[0].val <= rd ? queue[rd_ptr] : '0;
                for (int j = 1; j <= r; j++)
                    dly[j] <= dly[j-1];
            end
        end

        assign west[r] = dly[r];
    end

endmodule

//--- hw/mac_array.sv
`include "corelet_macros.svh"

module mac_array (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  corelet_pkg::lane_t      west [`ARRAY_DIM],
    output corelet_pkg::psum_row_t  out_s,
    output logic [`ARRAY_DIM-1:0]   col_valid
);

    // lane_h[r][c] enters tile (r,c) from the west, psum_v[r][c] from the north
    corelet_pkg::lane_t         lane_h  [`ARRAY_DIM][`ARRAY_DIM+1];
    logic signed [`PSUM_BW-1:0] psum_v  [`ARRAY_DIM+1][`ARRAY_DIM];
    logic                       valid_v [`ARRAY_DIM+1][`ARRAY_DIM];

    for (genvar r = 0; r < `ARRAY_DIM; r++)
    begin : g_row
        assign lane_h[r][0] = west[r];

        for (genvar c = 0; c < `ARRAY_DIM; c++)
        begin : g_col
            mac_tile u_tile (
                .clk            (clk),
                .reset          (reset),
                .clear          (clear),
                .lane_in        (lane_h[r][c]),
                .psum_in        (psum_v[r][c]),
                .psum_valid_in  (valid_v[r][c]),
                .lane_out       (lane_h[r][c+1]),
                .psum_out       (psum_v[r+1][c]),
                .psum_valid_out (valid_v[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < `ARRAY_DIM; c++)
    begin : g_top
        assign psum_v[0][c]  = '0; // columns start from zero
        assign valid_v[0][c] = 1'b0;
    end

    always_comb
    begin
        for (int c = 0; c < `ARRAY_DIM; c++)
        begin
            out_s[c]     = psum_v[`ARRAY_DIM][c];
            col_valid[c] = valid_v[`ARRAY_DIM][c];
        end
    end

endmodule

//--- hw/mac_tile.sv
`include "corelet_macros.svh"

module mac_tile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clear,
    input  corelet_pkg::lane_t          lane_in,
    input  logic signed [`PSUM_BW-1:0]  psum_in,
    input  logic                        psum_valid_in,
    output corelet_pkg::lane_t          lane_out,
    output logic signed [`PSUM_BW-1:0]  psum_out,
    output logic                        psum_valid_out
);

    logic signed [`ACT_BW-1:0]  weight;
    logic                       loaded;
    logic                       take_w;
    logic                       exec;
    logic signed [`PSUM_BW-1:0] psum_base;
    logic signed [`PSUM_BW-1:0] prod;

    // first load word stays here, later ones move on east
    assign take_w    = (lane_in.op == corelet_pkg::OP_LOAD) && !loaded;
    assign exec      = (lane_in.op == corelet_pkg::OP_EXEC);
    assign psum_base = psum_valid_in ? psum_in : '0;
    assign prod      = $signed({1'b0, lane_in.val}) * weight; // unsigned act, signed weight

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset || clear)
        begin
            loaded         <= 1'b0;
            lane_out       <= '0;
            psum_valid_out <= 1'b0;
        end
        else
        begin
            psum_valid_out <= exec;
            if (take_w)
            begin
                loaded   <= 1'b1;
                lane_out <= '{op: corelet_pkg::OP_NONE, val: '0};
            end
            else
                lane_out <= lane_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_w)
            weight <= lane_in.val;
        if (exec)
            psum_out <= psum_base + prod; // wraps at 16 bits
    end

endmodule

//--- hw/corelet_pkg.sv
`include "corelet_macros.svh"

package corelet_pkg;

    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_L0,
        WEIGHT_ARRAY,
        ACT_L0,
        ACT_ARRAY,
        WEIGHT_CLEAR,
        RET_OUT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_EXEC
    } array_op_t;

    // input sram read request
    typedef struct packed {
        logic                 en;
        logic [`IADDR_BW-1:0] addr;
    } fetch_t;

    // one partial sum per column, column 0 in the low bits
    typedef logic [`ARRAY_DIM-1:0][`PSUM_BW-1:0] psum_row_t;

    typedef struct packed {
        logic                 en;
        logic [`OADDR_BW-1:0] addr;
        psum_row_t            data;
    } out_wr_t;

    // travels east between tiles
    typedef struct packed {
        array_op_t          op;
        logic [`ACT_BW-1:0] val;
    } lane_t;

endpackage

//--- hw/corelet_macros.svh
`ifndef CORELET_MACROS_SVH
`define CORELET_MACROS_SVH

// array geometry and data widths
`define ARRAY_DIM 8
`define ACT_BW 4
`define PSUM_BW 16

// sram address widths
`define IADDR_BW 7
`define OADDR_BW 4

// 4x4 output pixels, 3x3 kernel positions
`define NUM_OUT 16
`define NUM_KIJ 9
`define ACT_BASE 72 // first activation word in the input sram

// phase lengths in cycles
`define LEN_WEIGHT_L0 9
`define LEN_WEIGHT_ARRAY 25
`define LEN_ACT_L0 17
`define LEN_ACT_ARRAY 37
`define LEN_WEIGHT_CLEAR 17
`define LEN_RET_OUT 17

`endif
